//--- source/cache_geometry_pkg.sv
/*
  Geometry of the data cache line store.
  A line address is a 20-bit tag over a 6-bit index, giving 64 direct-mapped sets.
  Lines are 512 bits wide and always handled whole, with no byte access.
  Changing the widths here changes every block that uses them.
*/

package cache_geometry_pkg;

    // tag part of the line address
    localparam int tag_w = 20;

    // set index into the first-level array
    localparam int index_w = 6;

    // full line width in bits
    localparam int line_w = 512;

    // line address, tag on top and index below
    typedef struct packed {
        logic [tag_w-1:0]   tag;
        logic [index_w-1:0] index;
    } line_addr_t;

    // one cache line of payload
    typedef logic [line_w-1:0] line_data_t;

endpackage

//--- source/cache_port_pkg.sv
/*
  Port structures for the line store.
  All strobes are single-cycle valid bits with no ready and no back-pressure.
  Refill and eviction carry the same fields. Eviction is the line pushed out
  of the first level.
*/

package cache_port_pkg;

    // lookup strobe with the line address
    typedef struct packed {
        logic                           valid;
        cache_geometry_pkg::line_addr_t addr;
    } lookup_req_t;

    // external line write into the first level
    typedef struct packed {
        logic                           valid;
        cache_geometry_pkg::line_addr_t addr;
        cache_geometry_pkg::line_data_t data;
    } refill_t;

    // line displaced from the first level
    typedef struct packed {
        logic                           valid;
        cache_geometry_pkg::line_addr_t addr;
        cache_geometry_pkg::line_data_t data;
    } evict_t;

    // where a lookup was answered from
    typedef enum logic [1:0] {
        src_miss   = 2'd0,
        src_l1     = 2'd1,
        src_victim = 2'd2
    } hit_source_e;

    // response, valid one cycle after the request
    typedef struct packed {
        logic                           valid;
        hit_source_e                    src;
        cache_geometry_pkg::line_data_t data;
    } lookup_resp_t;

endpackage

//--- source/l1_line_array.sv
/*
  Direct-mapped first-level line array, 64 sets, one line per set.
  Lookup is combinational on the current array contents.
  A refill writes its set at the clock edge. A valid line with another tag
  in that set leaves through evict during the next cycle.
  A refill with the same tag overwrites in place and evicts nothing.
*/

`timescale 1ns/100ps

module l1_line_array (
    input  logic                           clk,
    input  logic                           rstn,
    input  cache_port_pkg::refill_t        refill,
    input  cache_geometry_pkg::line_addr_t lookup_addr,
    output logic                           l1_hit,
    output cache_geometry_pkg::line_data_t l1_data,
    output cache_port_pkg::evict_t         evict
);

    localparam int sets = 2 ** cache_geometry_pkg::index_w;

    // storage arrays, contents qualified by valid_q
    logic [cache_geometry_pkg::tag_w-1:0] tag_mem  [sets];
    cache_geometry_pkg::line_data_t       data_mem [sets];
    logic [sets-1:0]                      valid_q;

    // registered eviction
    logic                           evict_valid_q;
    cache_geometry_pkg::line_addr_t evict_addr_q;
    cache_geometry_pkg::line_data_t evict_data_q;

    logic                                 displace;
    logic [cache_geometry_pkg::tag_w-1:0] old_tag;

    // read side
    assign l1_hit  = valid_q[lookup_addr.index] && (tag_mem[lookup_addr.index] == lookup_addr.tag);
    assign l1_data = data_mem[lookup_addr.index];

    // old occupant of the refill set
    assign old_tag  = tag_mem[refill.addr.index];
    assign displace = refill.valid && valid_q[refill.addr.index] && (old_tag != refill.addr.tag);

    // valid bits and eviction strobe
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q       <= '0;
            evict_valid_q <= 1'b0;
        end else begin
            evict_valid_q <= displace;
            if (refill.valid) begin
                valid_q[refill.addr.index] <= 1'b1;
            end
        end
    end

    // array write plus capture of the displaced line before it is lost
    always_ff @(posedge clk) begin
        if (displace) begin
            evict_addr_q.tag   <= old_tag;
            evict_addr_q.index <= refill.addr.index;
            evict_data_q       <= data_mem[refill.addr.index];
        end
        if (refill.valid) begin
            tag_mem[refill.addr.index]  <= refill.addr.tag;
            data_mem[refill.addr.index] <= refill.data;
        end
    end

    assign evict = '{valid: evict_valid_q, addr: evict_addr_q, data: evict_data_q};

endmodule

//--- source/victim_cache.sv
/*
  Fully associative victim store for lines evicted from the first level.
  victim_entries must be a power of two from 2 to 16, so the write counter wraps.
  Replacement is round-robin: every eviction takes the counter slot.
  An invalidate clears every entry holding its address, so a refilled line
  never keeps a stale copy here. Lookup returns the lowest matching entry.
*/

`timescale 1ns/100ps

module victim_cache #(
    parameter int victim_entries = 4
) (
    input  logic                           clk,
    input  logic                           rstn,
    input  cache_port_pkg::evict_t         evict,
    input  cache_geometry_pkg::line_addr_t inval_addr,
    input  logic                           inval,
    input  cache_geometry_pkg::line_addr_t lookup_addr,
    output logic                           victim_hit,
    output cache_geometry_pkg::line_data_t victim_data
);

    localparam int ptr_w = $clog2(victim_entries);

    // full line address per entry, no index split
    cache_geometry_pkg::line_addr_t addr_mem [victim_entries];
    cache_geometry_pkg::line_data_t data_mem [victim_entries];
    logic [victim_entries-1:0]      valid_q;

    // next slot to overwrite
    logic [ptr_w-1:0] wr_ptr;

    logic [victim_entries-1:0] hit_vec;
    logic [victim_entries-1:0] inval_vec;

    // per-entry compares
    always_comb begin
        for (int i = 0; i < victim_entries; i++) begin
            hit_vec[i]   = valid_q[i] && (addr_mem[i] == lookup_addr);
            inval_vec[i] = inval && valid_q[i] && (addr_mem[i] == inval_addr);
        end
    end

    assign victim_hit = |hit_vec;

    // walk down so the lowest hit ends up selected
    always_comb begin
        victim_data = '0;
        for (int i = victim_entries - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                victim_data = data_mem[i];
            end
        end
    end

    // valid bits and replacement counter
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
            wr_ptr  <= '0;
        end else begin
            valid_q <= valid_q & ~inval_vec;
            // eviction sets its slot after the clear, evicted and refilled
            // addresses always differ in tag
            if (evict.valid) begin
                valid_q[wr_ptr] <= 1'b1;
                wr_ptr          <= wr_ptr + 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (evict.valid) begin
            addr_mem[wr_ptr] <= evict.addr;
            data_mem[wr_ptr] <= evict.data;
        end
    end

endmodule

//--- source/lookup_merge.sv
/*
  Merges the two store results into one registered response.
  First level wins over victim; neither hit gives src_miss with zero data.
  The response is valid exactly one cycle after each lookup strobe.
*/

`timescale 1ns/100ps

module lookup_merge (
    input  logic                           clk,
    input  logic                           rstn,
    input  cache_port_pkg::lookup_req_t    lookup_req,
    input  logic                           l1_hit,
    input  cache_geometry_pkg::line_data_t l1_data,
    input  logic                           victim_hit,
    input  cache_geometry_pkg::line_data_t victim_data,
    output cache_port_pkg::lookup_resp_t   lookup_resp
);

    cache_port_pkg::hit_source_e    src_d;
    cache_port_pkg::hit_source_e    src_q;
    cache_geometry_pkg::line_data_t data_d;
    cache_geometry_pkg::line_data_t data_q;
    logic                           valid_q;

    // priority select
    always_comb begin
        if (l1_hit) begin
            src_d  = cache_port_pkg::src_l1;
            data_d = l1_data;
        end else if (victim_hit) begin
            src_d  = cache_port_pkg::src_victim;
            data_d = victim_data;
        end else begin
            src_d  = cache_port_pkg::src_miss;
            data_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= lookup_req.valid;
        end
    end

    // hold the last answer between lookups
    always_ff @(posedge clk) begin
        if (lookup_req.valid) begin
            src_q  <= src_d;
            data_q <= data_d;
        end
    end

    assign lookup_resp = '{valid: valid_q, src: src_q, data: data_q};

endmodule

//--- source/dcache_line_store.sv
/*
  Line store of the data cache, a direct-mapped first level backed by a
  small fully associative victim cache.
  Strobes only, no back-pressure. Do not issue a lookup in the cycle right
  after a refill while the evicted line is still on its way to the victim.
  Miss handling, write-back and victim-to-first-level swap are outside.
*/

`timescale 1ns/100ps

module dcache_line_store #(
    parameter int victim_entries = 4
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  cache_port_pkg::lookup_req_t  lookup_req,
    input  cache_port_pkg::refill_t      refill,
    output cache_port_pkg::lookup_resp_t lookup_resp
);

    cache_port_pkg::evict_t         evict;
    logic                           l1_hit;
    cache_geometry_pkg::line_data_t l1_data;
    logic                           victim_hit;
    cache_geometry_pkg::line_data_t victim_data;

    l1_line_array i_l1_line_array (
        .clk         (clk),
        .rstn        (rstn),
        .refill      (refill),
        .lookup_addr (lookup_req.addr),
        .l1_hit      (l1_hit),
        .l1_data     (l1_data),
        .evict       (evict)
    );

    // a refill also drops any copy of its line from the victim store
    victim_cache #(
        .victim_entries (victim_entries)
    ) i_victim_cache (
        .clk         (clk),
        .rstn        (rstn),
        .evict       (evict),
        .inval_addr  (refill.addr),
        .inval       (refill.valid),
        .lookup_addr (lookup_req.addr),
        .victim_hit  (victim_hit),
        .victim_data (victim_data)
    );

    lookup_merge i_lookup_merge (
        .clk         (clk),
        .rstn        (rstn),
        .lookup_req  (lookup_req),
        .l1_hit      (l1_hit),
        .l1_data     (l1_data),
        .victim_hit  (victim_hit),
        .victim_data (victim_data),
        .lookup_resp (lookup_resp)
    );

endmodule

//--- verification/dcache_line_store_tb.sv
/*
  Testbench for the line store with a four-entry victim cache.
  Inputs change on the falling edge, responses are read on the falling edge.
  Refills are followed by one idle cycle so no lookup meets an eviction in transit.
  The run stops at the first error.
*/

`timescale 1ns/100ps

module dcache_line_store_tb;

    localparam int victim_entries = 4;
    localparam int sets           = 2 ** cache_geometry_pkg::index_w;
    localparam int resp_timeout   = 8;

    logic                         clk;
    logic                         rstn;
    cache_port_pkg::lookup_req_t  lookup_req;
    cache_port_pkg::refill_t      refill;
    cache_port_pkg::lookup_resp_t lookup_resp;

    // reference model of both stores
    logic [cache_geometry_pkg::tag_w-1:0] model_l1_tag   [sets];
    cache_geometry_pkg::line_data_t       model_l1_data  [sets];
    logic                                 model_l1_valid [sets];
    cache_geometry_pkg::line_addr_t       model_vc_addr  [victim_entries];
    cache_geometry_pkg::line_data_t       model_vc_data  [victim_entries];
    logic                                 model_vc_valid [victim_entries];
    int                                   model_vc_ptr;

    integer seed;

    dcache_line_store #(
        .victim_entries (victim_entries)
    ) i_dcache_line_store (
        .clk         (clk),
        .rstn        (rstn),
        .lookup_req  (lookup_req),
        .refill      (refill),
        .lookup_resp (lookup_resp)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // exactly one response per lookup, one cycle later
    resp_follows_req: assert property (
        @(posedge clk) disable iff (!rstn)
        lookup_resp.valid == $past(lookup_req.valid)
    ) else stop_on_error("lookup response valid does not follow the lookup strobe");

    function automatic cache_geometry_pkg::line_data_t random_line();
        cache_geometry_pkg::line_data_t line;
        for (int i = 0; i < cache_geometry_pkg::line_w / 32; i++) begin
            line[i*32 +: 32] = $random(seed);
        end
        return line;
    endfunction

    function automatic cache_geometry_pkg::line_addr_t make_addr(input int tag, input int index);
        cache_geometry_pkg::line_addr_t addr;
        addr.tag   = tag[cache_geometry_pkg::tag_w-1:0];
        addr.index = index[cache_geometry_pkg::index_w-1:0];
        return addr;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < sets; i++) begin
            model_l1_valid[i] = 1'b0;
        end
        for (int i = 0; i < victim_entries; i++) begin
            model_vc_valid[i] = 1'b0;
        end
        model_vc_ptr = 0;
    endtask

    task automatic model_refill(input cache_geometry_pkg::line_addr_t addr,
                                input cache_geometry_pkg::line_data_t data);
        int idx;
        idx = int'(addr.index);
        // a refilled line keeps no copy in the victim
        for (int i = 0; i < victim_entries; i++) begin
            if (model_vc_valid[i] && model_vc_addr[i] == addr) begin
                model_vc_valid[i] = 1'b0;
            end
        end
        // different valid tag moves to the round-robin slot
        if (model_l1_valid[idx] && model_l1_tag[idx] != addr.tag) begin
            model_vc_addr[model_vc_ptr].tag   = model_l1_tag[idx];
            model_vc_addr[model_vc_ptr].index = addr.index;
            model_vc_data[model_vc_ptr]       = model_l1_data[idx];
            model_vc_valid[model_vc_ptr]      = 1'b1;
            model_vc_ptr = (model_vc_ptr + 1) % victim_entries;
        end
        model_l1_valid[idx] = 1'b1;
        model_l1_tag[idx]   = addr.tag;
        model_l1_data[idx]  = data;
    endtask

    task automatic predict(input cache_geometry_pkg::line_addr_t addr,
                           output cache_port_pkg::hit_source_e src,
                           output cache_geometry_pkg::line_data_t data);
        int   idx;
        logic found;
        idx   = int'(addr.index);
        src   = cache_port_pkg::src_miss;
        data  = '0;
        found = 1'b0;
        if (model_l1_valid[idx] && model_l1_tag[idx] == addr.tag) begin
            src   = cache_port_pkg::src_l1;
            data  = model_l1_data[idx];
            found = 1'b1;
        end
        // lowest matching victim entry answers
        for (int i = 0; i < victim_entries; i++) begin
            if (!found && model_vc_valid[i] && model_vc_addr[i] == addr) begin
                src   = cache_port_pkg::src_victim;
                data  = model_vc_data[i];
                found = 1'b1;
            end
        end
    endtask

    task automatic do_refill(input cache_geometry_pkg::line_addr_t addr,
                             input cache_geometry_pkg::line_data_t data);
        refill.valid = 1'b1;
        refill.addr  = addr;
        refill.data  = data;
        model_refill(addr, data);
        @(negedge clk);
        refill.valid = 1'b0;
        // eviction still on its way to the victim
        @(negedge clk);
    endtask

    task automatic check_resp(input string test_name,
                              input cache_port_pkg::hit_source_e exp_src,
                              input cache_geometry_pkg::line_data_t exp_data);
        cache_port_pkg::hit_source_e got_src;
        got_src = lookup_resp.src;
        assert (got_src == exp_src) else
            stop_on_error($sformatf("ERR %s source expected %s actual %s",
                                    test_name, exp_src.name(), got_src.name()));
        assert (lookup_resp.data == exp_data) else
            stop_on_error($sformatf("ERR %s data expected %h actual %h",
                                    test_name, exp_data, lookup_resp.data));
    endtask

    task automatic do_lookup(input string test_name, input cache_geometry_pkg::line_addr_t addr);
        cache_port_pkg::hit_source_e    exp_src;
        cache_geometry_pkg::line_data_t exp_data;
        int                             waited;
        predict(addr, exp_src, exp_data);
        lookup_req.valid = 1'b1;
        lookup_req.addr  = addr;
        waited = 0;
        do begin
            @(negedge clk);
            lookup_req.valid = 1'b0;
            waited++;
        end while (!lookup_resp.valid && waited < resp_timeout);
        if (!lookup_resp.valid) begin
            stop_on_error($sformatf("%s: no lookup response within %0d cycles",
                                    test_name, resp_timeout));
        end
        check_resp(test_name, exp_src, exp_data);
    endtask

    task automatic check_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            assert (!lookup_resp.valid) else
                stop_on_error("a lookup response appeared without a lookup");
        end
    endtask

    initial begin
        int op;
        int tag;
        int idx;
        cache_geometry_pkg::line_data_t new_data;

        seed       = 32'he87b_e79b;
        rstn       = 1'b0;
        lookup_req = '0;
        refill     = '0;
        clear_model();
        repeat (4) @(negedge clk);
        rstn = 1'b1;

        // empty stores after reset
        check_idle(4);
        for (int i = 0; i < 4; i++) begin
            do_lookup("reset_miss", make_addr($random(seed), $random(seed)));
        end
        check_idle(3);

        // first-level hit, then other tag on the same set
        do_refill(make_addr(20'h000a1, 7), random_line());
        do_lookup("refill_hit", make_addr(20'h000a1, 7));
        do_lookup("same_index_other_tag", make_addr(20'h000a2, 7));

        // conflict pushes the old line into the victim
        do_refill(make_addr(20'h000b2, 7), random_line());
        do_lookup("evicted_to_victim", make_addr(20'h000a1, 7));
        do_lookup("new_tag_in_l1", make_addr(20'h000b2, 7));

        // six refills on one set give five evictions into four entries
        for (int t = 0; t < 6; t++) begin
            do_refill(make_addr(20'h00100 + t, 12), random_line());
        end
        for (int t = 0; t < 6; t++) begin
            do_lookup("victim_overflow", make_addr(20'h00100 + t, 12));
        end
        do_lookup("victim_overflow_old", make_addr(20'h000a1, 7));

        // refill of a victim-held line drops the stale copy
        new_data = random_line();
        do_refill(make_addr(20'h00103, 12), new_data);
        do_lookup("victim_refill_l1", make_addr(20'h00103, 12));
        do_refill(make_addr(20'h00106, 12), random_line());
        do_lookup("reevicted_new_data", make_addr(20'h00103, 12));

        // random mix over three sets and five tags
        for (int n = 0; n < 200; n++) begin
            op  = $unsigned($random(seed)) % 2;
            tag = 20'h00200 + $unsigned($random(seed)) % 5;
            idx = 20 + $unsigned($random(seed)) % 3;
            if (op == 0) begin
                do_refill(make_addr(tag, idx), random_line());
            end else begin
                do_lookup("random_mix", make_addr(tag, idx));
            end
        end
        check_idle(2);

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- dcache_line_store.f
source/cache_geometry_pkg.sv
source/cache_port_pkg.sv
source/l1_line_array.sv
source/victim_cache.sv
source/lookup_merge.sv
source/dcache_line_store.sv
verification/dcache_line_store_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the line store testbench with Verilator and runs it.
# Exits with a non-zero status when the build, the run or the log check fails.

top=dcache_line_store_tb
build_log=build.log
sim_log=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module "$top" \
    -f dcache_line_store.f -o "$top" > "$build_log" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$build_log"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/"$top" > "$sim_log" 2>&1
status=$?
cat "$sim_log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "TEST FAILED" "$sim_log"
status=$?
if [ $status -eq 0 ]; then
    echo "failure reported in $sim_log"
    exit 1
elif [ $status -ne 1 ]; then
    echo "could not search $sim_log"
    exit 1
fi

echo "simulation finished without reported failures"
exit 0
